/* build.f */
rx_pkg.sv
rx_frame_align.sv
rx_protocol_decode.sv
rx_cfg_apb.sv
erx_top.sv
erx_props.sv
tb_erx_top.sv

/* Makefile */
# Verilator flow for the RX protocol stage

TOP = tb_erx_top
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_erx_top.sv */
/*
 * Testbench for erx_top that serializes a table of frames into 8-lane groups
 * and checks decoded packets in a scoreboard and the APB counters
 */

`timescale 1ns/10ps

module tb_erx_top;

   typedef struct {
      string       name;
      int          lane;                   // Lane of the header byte
      logic [3:0]  ctrl;
      logic [31:0] dst;
      logic [1:0]  dmode;
      logic        wr;
      logic [31:0] data;
      logic [31:0] src;
      int          stream;                 // Extra stream packets
      logic        en;
      int          gap;                    // Idle groups after the frame
   } row_t;

   logic                  rx_lclk_div4;
   logic                  reset;
   logic [7:0]            rx_frame_par;
   logic [63:0]           rx_data_par;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [3:0]            paddr;
   logic [31:0]           pwdata;
   logic [31:0]           prdata;
   logic                  pready;
   logic                  erx_access;
   logic [rx_pkg::PW-1:0] erx_packet;

   row_t                  rows[$];
   int                    row_err[$];
   logic [rx_pkg::PW-1:0] exp_pkt[$];      // Scoreboard
   int                    exp_row[$];
   bit                    exp_last[$];
   int                    errors = 0;
   int                    checks = 0;
   int                    tests = 0;
   int                    n_accept = 0;
   int                    n_drop = 0;

   erx_top #(
      .CNT_W (rx_pkg::CNT_W_DEFAULT)
   ) i_dut (
      .rx_lclk_div4 (rx_lclk_div4),
      .reset        (reset),
      .rx_frame_par (rx_frame_par),
      .rx_data_par  (rx_data_par),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .erx_access   (erx_access),
      .erx_packet   (erx_packet)
   );

   initial begin
      rx_lclk_div4 = 1'b0;
      forever #5 rx_lclk_div4 = ~rx_lclk_div4;
   end

   // ########################################################################
   // Stimulus helpers
   // ########################################################################

   task automatic add_row(input string nm, input int ln, input logic [3:0] c,
                          input logic [31:0] d, input logic [1:0] dm, input logic w,
                          input logic [31:0] dat, input logic [31:0] s, input int st,
                          input logic e, input int g);
      row_t r;
      r = '{nm, ln, c, d, dm, w, dat, s, st, e, g};
      rows.push_back(r);
      row_err.push_back(0);
   endtask

   // Stream packet k carries its own data and srcaddr
   function automatic logic [31:0] data_word(input row_t r, input int k);
      return r.data + 32'h0101_0101 * 32'(k);
   endfunction

   function automatic logic [31:0] src_word(input row_t r, input int k);
      return r.src + 32'h0000_1000 * 32'(k);
   endfunction

   function automatic logic [rx_pkg::PW-1:0] expect_packet(input row_t r, input int k);
      logic [rx_pkg::PW-1:0] p;
      p = '0;
      p[rx_pkg::PKT_WRITE]                      = r.wr;
      p[rx_pkg::PKT_DATAMODE_LSB +: 2]          = r.dmode;
      p[rx_pkg::PKT_CTRLMODE_LSB +: 4]          = r.ctrl;
      p[rx_pkg::PKT_DSTADDR_LSB +: rx_pkg::AW] = r.dst + rx_pkg::STREAM_INC * 32'(k);
      p[rx_pkg::PKT_DATA_LSB +: rx_pkg::DW]    = data_word(r, k);
      p[rx_pkg::PKT_SRCADDR_LSB +: rx_pkg::AW] = src_word(r, k);
      return p;
   endfunction

   // Byte b of a frame where byte 0 is the header
   function automatic logic [7:0] frame_byte(input row_t r, input int b);
      logic [31:0] w;
      int          k;
      int          o;
      k = (b - 6) / 8;
      o = (b - 6) % 8;
      case (b)
         1: return {r.ctrl, r.dst[31:28]};
         2: return r.dst[27:20];
         3: return r.dst[19:12];
         4: return r.dst[11:4];
         5: return {r.dst[3:0], r.dmode, r.wr, 1'b1};   // Access bit set
         default: ;
      endcase
      w = (o < 4) ? data_word(r, k) : src_word(r, k);
      return w[31 - 8 * (o % 4) -: 8];
   endfunction

   task automatic drive_group(input logic [7:0] f, input logic [63:0] d);
      @(posedge rx_lclk_div4);
      #1;
      rx_frame_par = f;
      rx_data_par  = d;
   endtask

   task automatic idle_groups(input int n);
      for (int i = 0; i < n; i++) begin
         drive_group(8'h00, {$urandom, $urandom});
      end
   endtask

   task automatic send_row(input row_t r);
      logic [7:0]  bytes[$];
      bit          frm[$];
      logic [7:0]  f;
      logic [63:0] d;
      for (int i = 0; i < 7 - r.lane; i++) begin
         bytes.push_back(8'($urandom));
         frm.push_back(1'b0);
      end
      bytes.push_back(8'($urandom));       // Header
      frm.push_back(1'b1);
      for (int b = 1; b < 14 + 8 * r.stream; b++) begin
         bytes.push_back(frame_byte(r, b));
         frm.push_back(1'b1);
      end
      // Frame drops for at least one byte before the pad to the group end
      do begin
         bytes.push_back(8'($urandom));
         frm.push_back(1'b0);
      end while (bytes.size() % 8 != 0);
      for (int g = 0; g < bytes.size() / 8; g++) begin
         for (int p = 0; p < 8; p++) begin
            d[63 - 8 * p -: 8] = bytes[8 * g + p];
            f[7 - p]           = frm[8 * g + p];
         end
         drive_group(f, d);
      end
      idle_groups(r.gap);
   endtask

   // APB slave has no wait states
   task automatic wait_ready();
      @(negedge rx_lclk_div4);
      if (pready !== 1'b1) begin
         $display("pready was not high in the first cycle of the APB access phase");
         errors++;
      end
      while (pready !== 1'b1) @(negedge rx_lclk_div4);
   endtask

   task automatic apb_write(input logic [3:0] a, input logic [31:0] v);
      @(posedge rx_lclk_div4);
      #1;
      psel    = 1'b1;
      pwrite  = 1'b1;
      paddr   = a;
      pwdata  = v;
      @(posedge rx_lclk_div4);
      #1;
      penable = 1'b1;
      wait_ready();
      @(posedge rx_lclk_div4);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [3:0] a, output logic [31:0] v);
      @(posedge rx_lclk_div4);
      #1;
      psel    = 1'b1;
      pwrite  = 1'b0;
      paddr   = a;
      @(posedge rx_lclk_div4);
      #1;
      penable = 1'b1;
      wait_ready();
      v = prdata;
      @(posedge rx_lclk_div4);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_reg(input string name, input logic [3:0] a, input logic [31:0] exp);
      logic [31:0] act;
      apb_read(a, act);
      checks++;
      tests++;
      if (act !== exp) begin
         $display("Fail %s expected %h actual %h", name, exp, act);
         errors++;
      end else begin
         $display("Test %s: pass", name);
      end
   endtask

   // ########################################################################
   // Scoreboard monitor sampled mid-cycle
   // ########################################################################

   always @(negedge rx_lclk_div4) begin : monitor
      logic [rx_pkg::PW-1:0] p;
      int                    ri;
      bit                    last;
      if (!reset && erx_access) begin
         if (exp_pkt.size() == 0) begin
            $display("Packet %h arrived with no packet expected", erx_packet);
            errors++;
         end else begin
            p    = exp_pkt.pop_front();
            ri   = exp_row.pop_front();
            last = exp_last.pop_front();
            checks++;
            if (erx_packet !== p) begin
               $display("Fail %s expected %h actual %h", rows[ri].name, p, erx_packet);
               errors++;
               row_err[ri]++;
            end
            if (last) begin
               tests++;
               $display("Test %s: %0d packets, %s", rows[ri].name,
                        rows[ri].stream + 1, (row_err[ri] == 0) ? "pass" : "fail");
            end
         end
      end
   end

   // Watchdog at four times the nominal length of all rows
   initial begin
      #1;
      #(rows.size() * 8 * 10 * 4);
      $display("Timeout: the run did not finish in the expected time");
      $display("STATUS: FAIL");
      $finish;
   end

   // ########################################################################
   // Main sequence
   // ########################################################################

   initial begin
      logic cur_en;
      void'($urandom(32'h5294));
      reset        = 1'b1;
      rx_frame_par = 8'h00;
      rx_data_par  = 64'h0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = 4'h0;
      pwdata       = 32'h0;

      add_row("lane7", 7, 4'h1, 32'h8000_1000, 2'd2, 1'b1,
              32'hA5A5_0001, 32'h1234_5670, 0, 1'b1, 1);
      add_row("lane6", 6, 4'h2, 32'h4000_2004, 2'd1, 1'b0,
              32'h5A5A_0002, 32'h2345_6781, 0, 1'b1, 0);
      add_row("lane5", 5, 4'h3, 32'h0123_4567, 2'd3, 1'b1,
              32'hDEAD_BEEF, 32'h89AB_CDEF, 0, 1'b1, 2);
      add_row("lane4", 4, 4'h4, 32'hFEDC_BA98, 2'd0, 1'b1,
              32'h0F0F_0F0F, 32'hF0F0_F0F0, 0, 1'b1, 0);
      add_row("lane3", 3, 4'h5, 32'h7654_3210, 2'd2, 1'b0,
              32'h1357_9BDF, 32'h2468_ACE0, 0, 1'b1, 1);
      add_row("lane2", 2, 4'h6, 32'hC0DE_0008, 2'd1, 1'b1,
              32'hCAFE_F00D, 32'h0000_0001, 0, 1'b1, 0);
      add_row("lane1", 1, 4'h7, 32'h1111_2222, 2'd3, 1'b0,
              32'h3333_4444, 32'h5555_6666, 0, 1'b1, 0);
      add_row("lane0", 0, 4'hF, 32'hABCD_EF01, 2'd2, 1'b1,
              32'h8888_9999, 32'hAAAA_BBBB, 0, 1'b1, 1);
      add_row("str_lane7", 7, 4'h9, 32'h2000_0000, 2'd3, 1'b1,
              32'h1000_0000, 32'h3000_0000, 3, 1'b1, 0);
      add_row("str_lane2", 2, 4'hA, 32'h2000_1000, 2'd2, 1'b0,
              32'h1000_1000, 32'h3000_1000, 2, 1'b1, 0);
      add_row("str_lane0", 0, 4'hB, 32'h2000_2000, 2'd1, 1'b1,
              32'h1000_2000, 32'h3000_2000, 1, 1'b1, 1);
      add_row("str_lane5", 5, 4'hC, 32'h2000_3000, 2'd0, 1'b1,
              32'h1000_3000, 32'h3000_3000, 1, 1'b1, 0);
      add_row("drop_lane4", 4, 4'hD, 32'h4444_0000, 2'd2, 1'b1,
              32'h4444_1111, 32'h4444_2222, 0, 1'b0, 0);
      add_row("drop_str_lane6", 6, 4'hE, 32'h6666_0000, 2'd1, 1'b0,
              32'h6666_1111, 32'h6666_2222, 2, 1'b0, 1);
      add_row("resume_lane3", 3, 4'h8, 32'h9999_0000, 2'd3, 1'b1,
              32'h9999_1111, 32'h9999_2222, 1, 1'b1, 0);

      repeat (3) @(posedge rx_lclk_div4);
      #1;
      reset = 1'b0;

      check_reg("reset_ctrl", rx_pkg::REG_CTRL, 32'h0);
      check_reg("reset_pkt_cnt", rx_pkg::REG_PKT_CNT, 32'h0);
      check_reg("reset_drop_cnt", rx_pkg::REG_DROP_CNT, 32'h0);

      cur_en = 1'b0;
      foreach (rows[i]) begin
         if (rows[i].en != cur_en) begin
            idle_groups(8);                // Let packets in flight leave stage 2
            apb_write(rx_pkg::REG_CTRL, {31'd0, rows[i].en});
            cur_en = rows[i].en;
         end
         for (int k = 0; k <= rows[i].stream; k++) begin
            if (rows[i].en) begin
               exp_pkt.push_back(expect_packet(rows[i], k));
               exp_row.push_back(i);
               exp_last.push_back(k == rows[i].stream);
               n_accept++;
            end else begin
               n_drop++;
            end
         end
         send_row(rows[i]);
         if (!rows[i].en) begin
            tests++;
            $display("Test %s: %0d packets sent with enable low", rows[i].name,
                     rows[i].stream + 1);
         end
      end
      idle_groups(8);

      tests++;
      checks++;
      if (exp_pkt.size() != 0) begin
         $display("Scoreboard still holds %0d packets that never arrived", exp_pkt.size());
         errors++;
      end else begin
         $display("Test scoreboard_empty: pass");
      end
      check_reg("pkt_count", rx_pkg::REG_PKT_CNT, 32'(n_accept));
      check_reg("drop_count", rx_pkg::REG_DROP_CNT, 32'(n_drop));
      apb_write(rx_pkg::REG_PKT_CNT, 32'h0);
      check_reg("pkt_clear", rx_pkg::REG_PKT_CNT, 32'h0);

      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* erx_props.sv */
/*
 * Protocol checks on erx_top strobes, enable gating and reset
 */

`timescale 1ns/10ps

module erx_props (
   input logic rx_lclk_div4,
   input logic reset,
   input logic erx_access,
   input logic rx_drop,
   input logic rx_enable
);

   // Accept and drop are mutually exclusive
   a_one_strobe: assert property (@(posedge rx_lclk_div4) disable iff (reset)
      !(erx_access && rx_drop))
      else $error("erx_access and rx_drop high in the same cycle");

   a_access_enabled: assert property (@(posedge rx_lclk_div4) disable iff (reset)
      erx_access |-> rx_enable)
      else $error("erx_access high while rx_enable is low");

   // Quiet output while reset is held
   a_reset_quiet: assert property (@(posedge rx_lclk_div4)
      reset |-> !erx_access)
      else $error("erx_access high during reset");

endmodule

bind erx_top erx_props i_props (
   .rx_lclk_div4 (rx_lclk_div4),
   .reset        (reset),
   .erx_access   (erx_access),
   .rx_drop      (rx_drop),
   .rx_enable    (rx_enable)
);

/* erx_top.sv */
/*
 * RX protocol stage top: frame aligner, protocol decoder and registers
 */

`timescale 1ns/10ps

module erx_top #(
   parameter int CNT_W = rx_pkg::CNT_W_DEFAULT
) (
   input  logic                  rx_lclk_div4,
   input  logic                  reset,
   // Deserializer side
   input  logic [7:0]            rx_frame_par,
   input  logic [63:0]           rx_data_par,
   // APB
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [3:0]            paddr,
   input  logic [31:0]           pwdata,
   output logic [31:0]           prdata,
   output logic                  pready,
   // Decoded packets
   output logic                  erx_access,
   output logic [rx_pkg::PW-1:0] erx_packet
);

   logic        align_active;
   logic [2:0]  align_lane;
   logic [63:0] data_q;
   logic [7:0]  frame_par;
   logic        rx_enable;
   logic        rx_drop;

   rx_frame_align i_align (
      .rx_lclk_div4 (rx_lclk_div4),
      .reset        (reset),
      .rx_frame_par (rx_frame_par),
      .rx_data_par  (rx_data_par),
      .align_active (align_active),
      .align_lane   (align_lane),
      .data_q       (data_q),
      .frame_par    (frame_par)
   );

   rx_protocol_decode i_decode (
      .rx_lclk_div4 (rx_lclk_div4),
      .reset        (reset),
      .align_active (align_active),
      .align_lane   (align_lane),
      .data_q       (data_q),
      .frame_par    (frame_par),
      .rx_enable    (rx_enable),
      .erx_access   (erx_access),
      .erx_packet   (erx_packet),
      .rx_drop      (rx_drop)
   );

   rx_cfg_apb #(
      .CNT_W (CNT_W)
   ) i_cfg (
      .rx_lclk_div4 (rx_lclk_div4),
      .reset        (reset),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .erx_access   (erx_access),
      .rx_drop      (rx_drop),
      .rx_enable    (rx_enable)
   );

endmodule

/* rx_cfg_apb.sv */
/*
 * RX register block: APB slave with receive enable and packet counters
 */

`timescale 1ns/10ps

module rx_cfg_apb #(
   parameter int CNT_W = rx_pkg::CNT_W_DEFAULT
) (
   input  logic        rx_lclk_div4,
   input  logic        reset,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [3:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   input  logic        erx_access,
   input  logic        rx_drop,
   output logic        rx_enable
);

   rx_pkg::rx_reg_e reg_sel;
   logic            wr_en;
   logic [CNT_W-1:0] pkt_cnt;
   logic [CNT_W-1:0] drop_cnt;

   assign reg_sel = rx_pkg::rx_reg_e'(paddr);
   assign wr_en   = psel & penable & pwrite;   // Access phase of a write
   assign pready  = 1'b1;                      // No wait states

   always_ff @(posedge rx_lclk_div4 or posedge reset) begin
      if (reset) begin
         rx_enable <= 1'b0;
         pkt_cnt   <= '0;
         drop_cnt  <= '0;
      end else begin
         if (wr_en && reg_sel == rx_pkg::REG_CTRL) begin
            rx_enable <= pwdata[0];
         end

         // Clear wins over a packet in the same cycle
         if (wr_en && reg_sel == rx_pkg::REG_PKT_CNT) begin
            pkt_cnt <= '0;
         end else if (erx_access && pkt_cnt != '1) begin
            pkt_cnt <= pkt_cnt + 1'b1;
         end

         if (wr_en && reg_sel == rx_pkg::REG_DROP_CNT) begin
            drop_cnt <= '0;
         end else if (rx_drop && drop_cnt != '1) begin
            drop_cnt <= drop_cnt + 1'b1;
         end
      end
   end

   // Read mux
   always_comb begin
      prdata = '0;
      case (reg_sel)
         rx_pkg::REG_CTRL:     prdata[0] = rx_enable;
         rx_pkg::REG_PKT_CNT:  prdata[CNT_W-1:0] = pkt_cnt;
         rx_pkg::REG_DROP_CNT: prdata[CNT_W-1:0] = drop_cnt;
         default: ;                            // Unmapped reads as zero
      endcase
   end

endmodule

/* rx_protocol_decode.sv */
/*
 * RX protocol decoder: three-stage field extraction from aligned groups,
 * stream mode handling, enable gating and 104-bit packet packing
 */

`timescale 1ns/10ps

module rx_protocol_decode (
   input  logic                   rx_lclk_div4,
   input  logic                   reset,
   input  logic                   align_active,
   input  logic [2:0]             align_lane,
   input  logic [63:0]            data_q,
   input  logic [7:0]             frame_par,
   input  logic                   rx_enable,
   output logic                   erx_access,
   output logic [rx_pkg::PW-1:0]  erx_packet,
   output logic                   rx_drop
);

   // Stage control
   logic [2:0]            lane_0, lane_1;
   logic                  active_0, active_1;
   logic                  stream_0, stream_1, stream_2;
   logic                  access_2;

   // Stage payload
   logic [3:0]            ctrlmode_0, ctrlmode_1, ctrlmode_2;
   logic [rx_pkg::AW-1:0] dstaddr_0, dstaddr_1, dstaddr_2;
   logic [1:0]            datamode_0, datamode_1, datamode_2;
   logic                  write_0, write_1, write_2;
   logic                  access_0, access_1;
   logic [15:0]           data_hi_0;       // Data bits 31:16
   logic [rx_pkg::DW-1:0] data_1, data_2;
   logic [rx_pkg::AW-1:0] srcaddr_1, srcaddr_2;

   // ########################################################################
   // Stage 0, first group after the frame edge
   // ########################################################################

   always_ff @(posedge rx_lclk_div4 or posedge reset) begin
      if (reset) begin
         active_0 <= 1'b0;
         lane_0   <= 3'd0;
         stream_0 <= 1'b0;
      end else begin
         active_0 <= align_active;
         lane_0   <= align_lane;
         // Lanes 7 and 6 see the next packet start in the current frame bits
         if (align_lane >= 3'd6) begin
            stream_0 <= frame_par[align_lane - 3'd6] & (align_active | stream_0);
         end else begin
            stream_0 <= 1'b0;
         end
      end
   end

   always_ff @(posedge rx_lclk_div4) begin
      case (align_lane)
         3'd7: begin
            ctrlmode_0 <= data_q[55:52];
            dstaddr_0  <= data_q[51:20];
            datamode_0 <= data_q[19:18];
            write_0    <= data_q[17];
            access_0   <= data_q[16];
            data_hi_0  <= data_q[15:0];
         end
         3'd6: begin
            ctrlmode_0      <= data_q[47:44];
            dstaddr_0       <= data_q[43:12];
            datamode_0      <= data_q[11:10];
            write_0         <= data_q[9];
            access_0        <= data_q[8];
            data_hi_0[15:8] <= data_q[7:0];
         end
         3'd5: begin
            ctrlmode_0 <= data_q[39:36];
            dstaddr_0  <= data_q[35:4];
            datamode_0 <= data_q[3:2];
            write_0    <= data_q[1];
            access_0   <= data_q[0];
         end
         3'd4: begin
            ctrlmode_0      <= data_q[31:28];
            dstaddr_0[31:4] <= data_q[27:0];
         end
         3'd3: begin
            ctrlmode_0       <= data_q[23:20];
            dstaddr_0[31:12] <= data_q[19:0];
         end
         3'd2: begin
            ctrlmode_0       <= data_q[15:12];
            dstaddr_0[31:20] <= data_q[11:0];
         end
         3'd1: begin
            ctrlmode_0       <= data_q[7:4];
            dstaddr_0[31:28] <= data_q[3:0];
         end
         default: ;                        // Lane 0 only has the header here
      endcase
   end

   // ########################################################################
   // Stage 1, second group
   // ########################################################################

   always_ff @(posedge rx_lclk_div4 or posedge reset) begin
      if (reset) begin
         active_1 <= 1'b0;
         lane_1   <= 3'd0;
         stream_1 <= 1'b0;
      end else begin
         active_1 <= active_0;
         lane_1   <= lane_0;
         if (lane_0 >= 3'd6) begin
            stream_1 <= stream_0;
         end else begin
            // Next packet starts at frame bit lane+2 of this group
            stream_1 <= frame_par[lane_0 + 3'd2] & (active_0 | stream_1);
         end
      end
   end

   always_ff @(posedge rx_lclk_div4) begin
      ctrlmode_1    <= ctrlmode_0;         // Pass-through unless overlaid below
      dstaddr_1     <= dstaddr_0;
      datamode_1    <= datamode_0;
      write_1       <= write_0;
      access_1      <= access_0;
      data_1[31:16] <= data_hi_0;
      case (lane_0)
         3'd7: begin
            data_1[15:0] <= data_q[63:48];
            srcaddr_1    <= data_q[47:16];
         end
         3'd6: begin
            data_1[23:0] <= data_q[63:40];
            srcaddr_1    <= data_q[39:8];
         end
         3'd5: begin
            data_1    <= data_q[63:32];
            srcaddr_1 <= data_q[31:0];
         end
         3'd4: begin
            dstaddr_1[3:0]  <= data_q[63:60];
            datamode_1      <= data_q[59:58];
            write_1         <= data_q[57];
            access_1        <= data_q[56];
            data_1          <= data_q[55:24];
            srcaddr_1[31:8] <= data_q[23:0];
         end
         3'd3: begin
            dstaddr_1[11:0]  <= data_q[63:52];
            datamode_1       <= data_q[51:50];
            write_1          <= data_q[49];
            access_1         <= data_q[48];
            data_1           <= data_q[47:16];
            srcaddr_1[31:16] <= data_q[15:0];
         end
         3'd2: begin
            dstaddr_1[19:0]  <= data_q[63:44];
            datamode_1       <= data_q[43:42];
            write_1          <= data_q[41];
            access_1         <= data_q[40];
            data_1           <= data_q[39:8];
            srcaddr_1[31:24] <= data_q[7:0];
         end
         3'd1: begin
            dstaddr_1[27:0] <= data_q[63:36];
            datamode_1      <= data_q[35:34];
            write_1         <= data_q[33];
            access_1        <= data_q[32];
            data_1          <= data_q[31:0];
         end
         default: begin                    // Lane 0, whole header word here
            ctrlmode_1   <= data_q[63:60];
            dstaddr_1    <= data_q[59:28];
            datamode_1   <= data_q[27:26];
            write_1      <= data_q[25];
            access_1     <= data_q[24];
            data_1[31:8] <= data_q[23:0];
         end
      endcase
   end

   // ########################################################################
   // Stage 2, third group and stream update
   // ########################################################################

   always_ff @(posedge rx_lclk_div4 or posedge reset) begin
      if (reset) begin
         stream_2 <= 1'b0;
         access_2 <= 1'b0;
      end else begin
         stream_2 <= stream_1;
         if (!stream_2) begin
            access_2 <= access_1 & active_1;
         end
      end
   end

   always_ff @(posedge rx_lclk_div4) begin
      if (stream_2) begin
         dstaddr_2 <= dstaddr_2 + rx_pkg::STREAM_INC;  // Header fields held
      end else begin
         ctrlmode_2 <= ctrlmode_1;
         dstaddr_2  <= dstaddr_1;
         datamode_2 <= datamode_1;
         write_2    <= write_1;
      end
      data_2    <= data_1;
      srcaddr_2 <= srcaddr_1;
      case (lane_1)
         3'd4: srcaddr_2[7:0]  <= data_q[63:56];
         3'd3: srcaddr_2[15:0] <= data_q[63:48];
         3'd2: srcaddr_2[23:0] <= data_q[63:40];
         3'd1: srcaddr_2       <= data_q[63:32];
         3'd0: begin
            data_2[7:0] <= data_q[63:56];
            srcaddr_2   <= data_q[55:24];
         end
         default: ;                        // Lanes 7 to 5 complete in stage 1
      endcase
   end

   // Enable splits the strobe into accept or drop
   assign erx_access = access_2 & rx_enable;
   assign rx_drop    = access_2 & ~rx_enable;

   // Packet packing
   always_comb begin
      erx_packet                                     = '0;
      erx_packet[rx_pkg::PKT_WRITE]                  = write_2;
      erx_packet[rx_pkg::PKT_DATAMODE_LSB +: 2]      = datamode_2;
      erx_packet[rx_pkg::PKT_CTRLMODE_LSB +: 4]      = ctrlmode_2;
      erx_packet[rx_pkg::PKT_DSTADDR_LSB +: rx_pkg::AW] = dstaddr_2;
      erx_packet[rx_pkg::PKT_DATA_LSB +: rx_pkg::DW]    = data_2;
      erx_packet[rx_pkg::PKT_SRCADDR_LSB +: rx_pkg::AW] = srcaddr_2;
   end

endmodule

/* rx_frame_align.sv */
/*
 * RX frame aligner: finds the rising frame edge in an 8-lane group and
 * registers its lane offset together with the data group
 */

`timescale 1ns/10ps

module rx_frame_align (
   input  logic        rx_lclk_div4,
   input  logic        reset,
   input  logic [7:0]  rx_frame_par,
   input  logic [63:0] rx_data_par,
   output logic        align_active,
   output logic [2:0]  align_lane,
   output logic [63:0] data_q,
   output logic [7:0]  frame_par
);

   logic       frame_prev;                 // Lane 0 frame bit of previous group
   logic [7:0] frame_rise;
   logic       edge_found;
   logic [2:0] edge_lane;

   // Each lane compares with its predecessor, lane 7 with the previous group
   assign frame_rise = rx_frame_par & ~{frame_prev, rx_frame_par[7:1]};

   // Highest lane wins, so the loop runs upward and later hits override
   always_comb begin
      edge_found = 1'b0;
      edge_lane  = 3'd0;
      for (int i = 0; i < 8; i++) begin
         if (frame_rise[i]) begin
            edge_found = 1'b1;
            edge_lane  = 3'(i);
         end
      end
   end

   always_ff @(posedge rx_lclk_div4 or posedge reset) begin
      if (reset) begin
         frame_prev   <= 1'b0;
         align_active <= 1'b0;
         align_lane   <= 3'd0;
      end else begin
         frame_prev   <= rx_frame_par[0];
         align_active <= edge_found;
         // Lane is held between edges, the stream path keeps using it
         if (edge_found) begin
            align_lane <= edge_lane;
         end
      end
   end

   // Data group, no reset needed
   always_ff @(posedge rx_lclk_div4) begin
      data_q <= rx_data_par;
   end

   // Current frame bits go straight on for stream detection
   assign frame_par = rx_frame_par;

endmodule

/* rx_pkg.sv */
/*
 * RX link package: link widths, packet field positions and APB register map
 */

package rx_pkg;

   // Link format widths
   localparam int PW = 104;                // Decoded packet width
   localparam int AW = 32;                 // Address width
   localparam int DW = 32;                 // Data width

   // ########################################################################
   // Packet field positions
   // ########################################################################

   localparam int PKT_WRITE        = 0;
   localparam int PKT_DATAMODE_LSB = 1;    // Bits 2:1
   localparam int PKT_CTRLMODE_LSB = 3;    // Bits 6:3, bit 7 stays zero
   localparam int PKT_DSTADDR_LSB  = 8;    // Bits 39:8
   localparam int PKT_DATA_LSB     = 40;   // Bits 71:40
   localparam int PKT_SRCADDR_LSB  = 72;   // Bits 103:72

   // dstaddr step from one stream packet to the next
   localparam logic [AW-1:0] STREAM_INC = 32'd8;

   // Default width of the packet counters
   localparam int CNT_W_DEFAULT = 16;

   // ########################################################################
   // APB register map, byte addresses of 32-bit words
   // ########################################################################

   typedef enum logic [3:0] {
      REG_CTRL     = 4'h0,                 // Bit 0 receive enable
      REG_PKT_CNT  = 4'h4,                 // Accepted packets, write clears
      REG_DROP_CNT = 4'h8                  // Dropped packets, write clears
   } rx_reg_e;

endpackage
